// File: logic/art_port.sv
`timescale 1ns/1ps

module art_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    we,
    input  logic [rv_pkg::XLEN-1:0] wdata,
    output logic [rv_pkg::XLEN-1:0] art_data,
    output logic                    art_strobe
);
    import rv_pkg::*;

    // Strobe marks the cycle in which new data first shows
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            art_data   <= '0;
            art_strobe <= 1'b0;
        end else begin
            art_strobe <= we;      // Core store strobe is one cycle
            if (we) begin
                art_data <= wdata;
            end
        end
    end

endmodule

// File: logic/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  rv_pkg::bus_req_t        core_req,
    output logic [rv_pkg::XLEN-1:0] core_rdata,
    output rv_pkg::bus_req_t        ram_req,
    input  logic [rv_pkg::XLEN-1:0] ram_rdata,
    output logic                    key_re,
    input  logic [rv_pkg::XLEN-1:0] key_rdata,
    output logic                    art_we,
    output logic [rv_pkg::XLEN-1:0] art_wdata
);
    import rv_pkg::*;

    logic sel_ram;
    logic sel_key;
    logic sel_art;
    logic ram_rd_q;  // Read in flight from RAM
    logic key_rd_q;  // Read in flight from key port

    // Address map
    assign sel_ram = (core_req.addr >= DATA_BASE) && (core_req.addr < KEY_BASE);
    assign sel_key = (core_req.addr == KEY_BASE);
    assign sel_art = (core_req.addr == ART_BASE);

    // Strobes reach only the matching slave
    always_comb begin
        ram_req    = core_req;
        ram_req.we = core_req.we & sel_ram;
        ram_req.re = core_req.re & sel_ram;
    end

    assign key_re    = core_req.re & sel_key;  // Stores to the key register dropped
    assign art_we    = core_req.we & sel_art;  // Art loads never strobe a slave
    assign art_wdata = core_req.wdata;

    // Slaves answer one cycle after the strobe
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ram_rd_q <= 1'b0;
            key_rd_q <= 1'b0;
        end else begin
            ram_rd_q <= core_req.re & sel_ram;
            key_rd_q <= core_req.re & sel_key;
        end
    end

    // Unmapped and art reads return zero
    assign core_rdata = ram_rd_q ? ram_rdata :
                        key_rd_q ? key_rdata : '0;

endmodule

// File: logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_WORDS = 256  // Depth in 64 bit words
) (
    input  logic                    clk,
    input  rv_pkg::bus_req_t        req,
    output logic [rv_pkg::XLEN-1:0] rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] mem [RAM_WORDS];
    logic [XLEN-1:0] offset;    // Byte offset from DATA_BASE
    logic [XLEN-4:0] word_num;  // Offset in words
    int unsigned     idx;

    assign offset   = req.addr - DATA_BASE;
    assign word_num = offset[XLEN-1:3];  // Low three bits ignored

    // Wraps inside the array for any depth
    assign idx = int'(word_num % RAM_WORDS);

    always_ff @(posedge clk) begin
        if (req.we) mem[idx] <= req.wdata;
        if (req.re) rdata <= mem[idx];  // Registered, valid next cycle
    end

endmodule

// File: logic/key_port.sv
`timescale 1ns/1ps

module key_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [rv_pkg::XLEN-1:0] key,      // Asynchronous to clk
    input  logic                    re,
    output logic [rv_pkg::XLEN-1:0] rdata,
    output logic                    irq,
    input  logic                    irq_ack
);
    import rv_pkg::*;

    logic [XLEN-1:0] key_s1;   // First synchroniser stage
    logic [XLEN-1:0] key_s2;   // Second synchroniser stage
    logic [XLEN-1:0] key_reg;  // Value the core reads
    logic            changed;

    assign changed = (key_s2 != key_reg);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            key_s1  <= '0;
            key_s2  <= '0;
            key_reg <= '0;
            irq     <= 1'b0;
            rdata   <= '0;
        end else begin
            key_s1 <= key;
            key_s2 <= key_s1;
            if (changed) key_reg <= key_s2;

            // A fresh change beats an acknowledge in the same cycle
            if (irq_ack) irq <= 1'b0;
            if (changed) irq <= 1'b1;

            if (re) rdata <= key_reg;  // Same latency as the RAM
        end
    end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    reset,        // Active low
    input  logic [31:0]             instruction,  // Word at pc, same cycle
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    heartbeat,
    input  logic                    irq,          // Level from key port
    output logic                    irq_ack,      // One cycle pulse on entry
    output logic                    in_handler,
    output rv_pkg::bus_req_t        bus_req,
    input  logic [rv_pkg::XLEN-1:0] rdata
);
    import rv_pkg::*;

    localparam logic [31:0] INSN_NOP = 32'h0000_0013;  // addi x0,x0,0

    logic [31:0]     ir;
    logic [XLEN-1:0] regs [32];   // No reset, x0 masked on read
    logic [XLEN-1:0] mepc;
    logic            bubble;      // Next ir slot is a flushed fetch
    logic [1:0]      ld_step;     // 0 idle, 1 wait, 2 write back
    logic            st_step;     // 1 while the write is on the bus
    logic [4:0]      ld_rd;       // Load target, ir has moved on by write back

    // Instruction fields
    logic [6:0]      opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    // Decode and control
    logic is_lui;
    logic is_addi;
    logic is_load;
    logic is_store;
    logic is_mret;
    logic is_plain;
    logic busy;
    logic take_irq;

    // Register file write port
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];

    // Sign extended immediates
    assign imm_i = {{(XLEN-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {{(XLEN-32){ir[31]}}, ir[31:12], 12'b0};

    assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
    assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];

    assign is_lui   = (opcode == OP_LUI);
    assign is_addi  = (opcode == OP_OPIMM);
    assign is_load  = (opcode == OP_LOAD);
    assign is_store = (opcode == OP_STORE);
    assign is_mret  = (ir == INSN_MRET);
    assign is_plain = !is_load && !is_store && !is_mret;  // Done in one cycle

    assign busy = (ld_step != 2'd0) || st_step;

    // Interrupt waits for loads, stores and MRET to finish
    // A plain instruction in ir still retires alongside the entry
    assign take_irq = irq && !in_handler && !busy && (bubble || is_plain);

    // Load write back has priority, ir then holds the next instruction
    always_comb begin
        rf_we    = 1'b0;
        rf_waddr = rd;
        rf_wdata = rs1_val + imm_i;  // ADDI
        if (ld_step == 2'd2) begin
            rf_we    = 1'b1;
            rf_waddr = ld_rd;
            rf_wdata = rdata;  // Valid two cycles after re
        end else if (!busy && !bubble && (is_lui || is_addi)) begin
            rf_we = 1'b1;
            if (is_lui) rf_wdata = imm_u;
        end
    end

    always_ff @(posedge clk) begin
        if (rf_we) regs[rf_waddr] <= rf_wdata;
    end

    // Fetch stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir        <= INSN_NOP;
            heartbeat <= 1'b0;
        end else begin
            ir        <= instruction;
            heartbeat <= ~heartbeat;
        end
    end

    // Execute stage
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc         <= RESET_PC;
            mepc       <= '0;
            bubble     <= 1'b0;
            ld_step    <= 2'd0;
            st_step    <= 1'b0;
            ld_rd      <= 5'd0;
            irq_ack    <= 1'b0;
            in_handler <= 1'b0;
            bus_req    <= '0;
        end else begin
            pc          <= pc + 64'd4;  // Overridden below where needed
            irq_ack     <= 1'b0;
            bus_req.we  <= 1'b0;
            bus_req.re  <= 1'b0;

            if (ld_step == 2'd1) begin
                pc      <= pc;  // Still waiting on the RAM
                ld_step <= 2'd2;
            end else if (ld_step == 2'd2) begin
                ld_step <= 2'd0;  // Register written this edge, fetch resumes
            end else if (st_step) begin
                st_step <= 1'b0;  // Slave takes the write this edge
            end else if (bubble) begin
                bubble <= 1'b0;  // Drop the stale fetch
            end else if (is_load) begin
                bus_req.addr <= rs1_val + imm_i;
                bus_req.re   <= 1'b1;
                ld_rd        <= rd;
                ld_step      <= 2'd1;
                pc           <= pc;  // Hold, refetch the next word later
            end else if (is_store) begin
                bus_req.addr  <= rs1_val + imm_s;
                bus_req.wdata <= rs2_val;
                bus_req.we    <= 1'b1;
                st_step       <= 1'b1;
                pc            <= pc;
            end else if (is_mret) begin
                pc         <= mepc;
                bubble     <= 1'b1;
                in_handler <= 1'b0;
            end

            // Interrupt entry wins over the default pc step
            if (take_irq) begin
                mepc       <= pc;  // Address of the word after ir
                pc         <= TRAP_VECTOR;
                bubble     <= 1'b1;
                irq_ack    <= 1'b1;
                in_handler <= 1'b1;
            end
        end
    end

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // Data path width of the RV64 core
    localparam int XLEN = 64;

    // Fixed program counter values
    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_0000_1000;  // First fetch after reset
    localparam logic [XLEN-1:0] TRAP_VECTOR = 64'h0000_0000_0000_0000;  // Interrupt handler entry

    // Data bus address map
    // RAM occupies everything from DATA_BASE up to the key register
    localparam logic [XLEN-1:0] DATA_BASE = 64'h0000_0000_0000_2000;
    localparam logic [XLEN-1:0] KEY_BASE  = 64'h0000_0000_0000_3000;  // Key register, read only
    localparam logic [XLEN-1:0] ART_BASE  = 64'h0000_0000_0000_3008;  // Art register, write only

    // Major opcodes, ir[6:0]
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_OPIMM = 7'b0010011;  // Only ADDI is executed
    localparam logic [6:0] OP_LOAD  = 7'b0000011;  // LD
    localparam logic [6:0] OP_STORE = 7'b0100011;  // SD

    // MRET is matched on the whole word
    localparam logic [31:0] INSN_MRET = 32'h3020_0073;

    // Request from the core onto the data bus
    // we and re are single cycle strobes with fixed latency
    typedef struct packed {
        logic [XLEN-1:0] addr;   // Byte address, 8 byte aligned
        logic [XLEN-1:0] wdata;  // Store data
        logic            we;     // Write strobe
        logic            re;     // Read strobe
    } bus_req_t;

endpackage

// File: logic/rv_system.sv
`timescale 1ns/1ps

module rv_system #(
    parameter int RAM_WORDS = 256
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             instruction,  // From external ROM
    output logic [rv_pkg::XLEN-1:0] pc,
    output logic                    heartbeat,
    input  logic [rv_pkg::XLEN-1:0] key,
    output logic [rv_pkg::XLEN-1:0] art_data,
    output logic                    art_strobe,
    output logic                    irq_ack,
    output logic                    in_handler
);
    import rv_pkg::*;

    bus_req_t        core_req;
    bus_req_t        ram_req;
    logic [XLEN-1:0] core_rdata;
    logic [XLEN-1:0] ram_rdata;
    logic [XLEN-1:0] key_rdata;
    logic [XLEN-1:0] art_wdata;
    logic            key_re;
    logic            art_we;
    logic            irq;

    rv_core core_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .heartbeat   (heartbeat),
        .irq         (irq),
        .irq_ack     (irq_ack),
        .in_handler  (in_handler),
        .bus_req     (core_req),
        .rdata       (core_rdata)
    );

    bus_decode decode_i (
        .clk        (clk),
        .reset      (reset),
        .core_req   (core_req),
        .core_rdata (core_rdata),
        .ram_req    (ram_req),
        .ram_rdata  (ram_rdata),
        .key_re     (key_re),
        .key_rdata  (key_rdata),
        .art_we     (art_we),
        .art_wdata  (art_wdata)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram_i (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

    key_port key_i (
        .clk     (clk),
        .reset   (reset),
        .key     (key),
        .re      (key_re),
        .rdata   (key_rdata),
        .irq     (irq),
        .irq_ack (irq_ack)
    );

    art_port art_i (
        .clk        (clk),
        .reset      (reset),
        .we         (art_we),
        .wdata      (art_wdata),
        .art_data   (art_data),
        .art_strobe (art_strobe)
    );

endmodule

// File: rv_system.f
logic/rv_pkg.sv
logic/rv_core.sv
logic/bus_decode.sv
logic/data_ram.sv
logic/key_port.sv
logic/art_port.sv
logic/rv_system.sv
test/tb_clock.sv
test/tb_rv_system.sv

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset,      // Active low
    input  logic reset_req   // Starts a fresh reset window
);
    int hold;  // Reset cycles still to go

    initial begin
        clk   = 1'b0;
        reset = 1'b0;
        hold  = RESET_CYCLES;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    // Reset moves only on the rising edge
    always @(posedge clk) begin
        if (reset_req) begin
            reset <= 1'b0;
            hold  <= RESET_CYCLES;
        end else if (hold > 0) begin
            hold <= hold - 1;
            if (hold == 1) reset <= 1'b1;  // Release after the last held cycle
        end
    end

endmodule

// File: test/tb_rv_system.sv
`timescale 1ns/1ps

module tb_rv_system;
    import rv_pkg::*;

    localparam logic [31:0] NOP_WORD    = 32'h0000_0013;  // addi x0,x0,0
    localparam int          CYCLE_LIMIT = 2000;  // Five tests need about 400 with resets

    logic            clk, reset, reset_req, heartbeat, art_strobe, irq_ack, in_handler;
    logic [31:0]     instruction;
    logic [XLEN-1:0] pc, key, art_data, pc_prev, ret_addr, key_a, key_b;
    logic [31:0]     rom [logic [XLEN-1:0]];  // Instruction ROM, sparse
    int              rom_gen;     // Bumped on every ROM change
    logic [XLEN-1:0] prog_addr;   // Next free ROM word
    int              prog_slot;   // Cycle in which the next word enters ir
    int              last_slot;
    logic [XLEN-1:0] exp_val [16];  // Shadow model of the art register
    int              exp_cyc [16];  // Strobe cycle, -1 where not fixed
    int              exp_wr, exp_rd, run_cycle, cycle_count, ack_count;
    int              errors, test_errors, tests_run, tests_failed;
    integer          seed;

    tb_clock clock_i (.clk(clk), .reset(reset), .reset_req(reset_req));

    rv_system #(.RAM_WORDS(256)) dut_i (
        .clk(clk), .reset(reset), .instruction(instruction), .pc(pc),
        .heartbeat(heartbeat), .key(key), .art_data(art_data),
        .art_strobe(art_strobe), .irq_ack(irq_ack), .in_handler(in_handler)
    );

    always @(pc or rom_gen) begin
        instruction = rom.exists(pc) ? rom[pc] : NOP_WORD;  // Same cycle as pc
    end

    always @(posedge clk) begin
        pc_prev <= pc;
        if (!reset) begin
            run_cycle <= 0;
            exp_rd    <= 0;
            ack_count <= 0;
        end else begin
            run_cycle <= run_cycle + 1;
            if (art_strobe) exp_rd <= exp_rd + 1;  // Shadow entry consumed
            if (irq_ack) begin
                ack_count <= ack_count + 1;
                ret_addr  <= pc_prev;  // pc when the entry was taken
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    assert property (@(posedge clk) $rose(reset) |->
        pc == RESET_PC && !art_strobe && !irq_ack && !in_handler)
        else flag_error("state after reset is wrong");
    assert property (@(posedge clk) disable iff (!reset)
        $past(reset) |-> heartbeat != $past(heartbeat))
        else flag_error("heartbeat did not toggle");
    assert property (@(posedge clk) disable iff (!reset) art_strobe |-> exp_rd < exp_wr)
        else flag_error("art_strobe with no store expected");
    assert property (@(posedge clk) disable iff (!reset)
        art_strobe && exp_rd < exp_wr |-> art_data == exp_val[exp_rd])
        else flag_error("art_data differs from the expected store value");
    assert property (@(posedge clk) disable iff (!reset)
        art_strobe && exp_rd < exp_wr && exp_cyc[exp_rd] >= 0 |-> run_cycle == exp_cyc[exp_rd])
        else flag_error("art_strobe came in the wrong cycle");
    assert property (@(posedge clk) disable iff (!reset)
        irq_ack |-> pc == TRAP_VECTOR && in_handler && !$past(in_handler))
        else flag_error("interrupt entry state is wrong");
    assert property (@(posedge clk) disable iff (!reset) irq_ack |=> !irq_ack)
        else flag_error("irq_ack longer than one cycle");
    assert property (@(posedge clk) disable iff (!reset) $fell(in_handler) |-> pc == ret_addr)
        else flag_error("pc after MRET is not the saved return address");

    // RISC-V encoders, only the forms the core runs
    function automatic logic [31:0] lui_insn(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction
    function automatic logic [31:0] addi_insn(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_OPIMM};
    endfunction
    function automatic logic [31:0] ld_insn(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, OP_LOAD};
    endfunction
    function automatic logic [31:0] sd_insn(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OP_STORE};
    endfunction
    function automatic logic [XLEN-1:0] sext12(input logic [11:0] imm);
        return {{(XLEN-12){imm[11]}}, imm};
    endfunction
    function automatic logic [XLEN-1:0] random_key(input logic [XLEN-1:0] prev);
        logic [XLEN-1:0] k;
        k = prev;
        while (k == prev || k == '0) k = {$random(seed), $random(seed)};  // Must raise irq
        return k;
    endfunction

    // Word occupies ir 1 cycle when plain, 2 for a store, 3 for a load
    task automatic emit(input logic [31:0] insn);
        rom[prog_addr] = insn;
        last_slot      = prog_slot;
        prog_addr      = prog_addr + 4;
        case (insn[6:0])
            OP_LOAD:  prog_slot = prog_slot + 3;
            OP_STORE: prog_slot = prog_slot + 2;
            default:  prog_slot = prog_slot + 1;
        endcase
        rom_gen++;
    endtask

    task automatic expect_art(input logic [XLEN-1:0] value, input int cyc);
        exp_val[exp_wr] = value;
        exp_cyc[exp_wr] = cyc;
        exp_wr++;
    endtask

    // Store rs2 to ART_BASE through x1 holding KEY_BASE, strobe two cycles after ir
    task automatic store_art(input logic [4:0] rs2, input logic [XLEN-1:0] value, input bit timed);
        emit(sd_insn(rs2, 5'd1, ART_BASE[11:0]));
        expect_art(value, timed ? last_slot + 2 : -1);
    endtask

    task automatic load_handler();
        prog_addr = TRAP_VECTOR;
        emit(lui_insn(5'd10, KEY_BASE[31:12]));
        emit(ld_insn(5'd11, 5'd10, 12'h000));   // Read key register
        emit(sd_insn(5'd11, 5'd10, ART_BASE[11:0]));
        emit(INSN_MRET);
    endtask

    task automatic begin_test();
        @(posedge clk);
        key       <= '0;  // Equals key register after reset
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(posedge clk);
        rom.delete();
        rom_gen++;
        exp_wr      = 0;
        prog_addr   = RESET_PC;
        prog_slot   = 1;  // First word reaches ir one cycle after release
        test_errors = errors;
    endtask

    task automatic wait_release();
        while (reset !== 1'b1) @(posedge clk);
    endtask

    task automatic end_test(input string name, input int acks);
        while (exp_rd < exp_wr) @(posedge clk);
        repeat (10) @(posedge clk);  // Room for a stray strobe
        assert (ack_count == acks)
            else flag_error($sformatf("irq_ack pulsed %0d times, not %0d", ack_count, acks));
        tests_run++;
        if (errors == test_errors) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail, %0d errors", name, errors - test_errors);
        end
    endtask

    initial begin
        seed      = 32'h86837f98;
        reset_req = 1'b0;
        key       = '0;
        key_a     = '0;

        begin_test();  // Reset state and heartbeat only
        wait_release();
        end_test("reset", 0);

        begin_test();
        emit(lui_insn(5'd2, 20'h80123));  // Upper bit set, sign extends
        emit(addi_insn(5'd2, 5'd2, 12'hffb));
        emit(lui_insn(5'd1, KEY_BASE[31:12]));
        store_art(5'd2, {{(XLEN-32){1'b1}}, 20'h80123, 12'h000} + sext12(12'hffb), 1'b1);
        wait_release();
        end_test("lui addi store", 0);

        begin_test();
        emit(lui_insn(5'd1, KEY_BASE[31:12]));
        emit(lui_insn(5'd4, DATA_BASE[31:12]));
        emit(addi_insn(5'd5, 5'd0, 12'h5a5));
        emit(sd_insn(5'd5, 5'd4, 12'h000));
        emit(addi_insn(5'd6, 5'd0, 12'ha5a));
        emit(sd_insn(5'd6, 5'd4, 12'h010));
        emit(addi_insn(5'd7, 5'd0, 12'h123));
        emit(sd_insn(5'd7, 5'd4, 12'h7f8));  // Last RAM word
        emit(ld_insn(5'd8, 5'd4, 12'h000));
        store_art(5'd8, sext12(12'h5a5), 1'b1);
        emit(ld_insn(5'd9, 5'd4, 12'h010));
        store_art(5'd9, sext12(12'ha5a), 1'b1);
        emit(ld_insn(5'd12, 5'd4, 12'h7f8));
        store_art(5'd12, sext12(12'h123), 1'b1);
        wait_release();
        end_test("ram round trip", 0);

        begin_test();
        load_handler();
        key_a = random_key(key_a);
        expect_art(key_a, -1);
        wait_release();
        @(posedge clk);
        key <= key_a;
        end_test("key path", 1);

        begin_test();
        emit(lui_insn(5'd1, KEY_BASE[31:12]));
        emit(addi_insn(5'd2, 5'd0, 12'h011));
        store_art(5'd2, sext12(12'h011), 1'b1);
        key_a = random_key(key_a);
        key_b = random_key(key_a);
        expect_art(key_a, -1);
        expect_art(key_b, -1);  // Second change served after MRET
        prog_addr = RESET_PC + 64'h100;  // NOPs up to here
        emit(addi_insn(5'd2, 5'd0, 12'h022));
        store_art(5'd2, sext12(12'h022), 1'b0);
        load_handler();
        wait_release();
        while (exp_rd < 1) @(posedge clk);
        key <= key_a;
        while (!irq_ack) @(posedge clk);
        repeat (2) @(posedge clk);  // Handler LD has read the first key
        assert (in_handler) else flag_error("second key change came after the handler");
        key <= key_b;
        end_test("interrupt", 2);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
